//--- logic/video_pkg.sv
/*
 * Video test-pattern source shared definitions
 * Frame geometry, buffer sizing, FSM encodings and the pixel word
 */
package video_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Pixel format
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int COMPONENTS  = 3;                        // R, G, B
    localparam int DATA_WIDTH  = 8;                        // Bits per component
    localparam int PIXEL_WIDTH = COMPONENTS * DATA_WIDTH;  // 24

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Frame geometry and counters
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int X_WIDTH   = 12;
    localparam int Y_WIDTH   = 12;
    localparam int F_WIDTH   = 16;
    localparam int FRAME_GAP = 4;                          // Idle cycles between frames
    localparam int GAP_WIDTH = $clog2(FRAME_GAP);

    // Output buffer depth doubles as the initial credit count
    localparam int BUF_DEPTH    = 2;
    localparam int PTR_WIDTH    = $clog2(BUF_DEPTH);
    localparam int CREDIT_WIDTH = $clog2(BUF_DEPTH + 1);   // Holds 0..BUF_DEPTH

    // Frame controller states
    localparam logic [1:0] ST_IDLE   = 2'd0;
    localparam logic [1:0] ST_ACTIVE = 2'd1;
    localparam logic [1:0] ST_GAP    = 2'd2;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Pixel word
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Component 0 sits in the low byte
    typedef union packed {
        logic [COMPONENTS-1:0][DATA_WIDTH-1:0] comp;       // Per-component view
        logic [PIXEL_WIDTH-1:0]                word;       // Flat view
    } pixel_t;

endpackage

//--- logic/frame_ctrl_fsm.sv
/*
 * Frame controller
 * Sequences idle, active and gap phases and gates pixel issue on
 * credits returned by the output buffer
 */
`timescale 1ns/1ps

module frame_ctrl_fsm import video_pkg::*; (
    input  logic               aclk,
    input  logic               aresetn,
    input  logic               enable,
    input  logic               line_end,
    input  logic               frame_end,
    input  logic               gap_done,
    input  logic               credit_return,
    output logic               step,
    output logic               gap_step,
    output logic               frame_load,
    output logic               issue_sof,
    output logic [F_WIDTH-1:0] gen_frame
);

    logic [1:0]              state;
    logic [1:0]              state_next;
    logic [CREDIT_WIDTH-1:0] credits;
    logic                    sof_pending;   // First issue of frame not yet done
    logic                    last_issue;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Issue gating
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign step       = (state == ST_ACTIVE) && (credits != '0);
    assign last_issue = step && line_end && frame_end;
    assign issue_sof  = sof_pending;

    always_comb begin
        state_next = state;
        frame_load = 1'b0;
        gap_step   = 1'b0;
        case (state)
            ST_IDLE: begin
                if (enable) begin
                    frame_load = 1'b1;     // Latch size on the way out of idle
                    state_next = ST_ACTIVE;
                end
            end
            ST_ACTIVE: begin
                if (last_issue) state_next = ST_GAP;
            end
            ST_GAP: begin
                gap_step = 1'b1;
                if (gap_done) begin
                    if (enable) begin
                        frame_load = 1'b1;
                        state_next = ST_ACTIVE;
                    end else begin
                        state_next = ST_IDLE;
                    end
                end
            end
            default: state_next = ST_IDLE;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // State, credits and frame index
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state       <= ST_IDLE;
            credits     <= CREDIT_WIDTH'(BUF_DEPTH);
            sof_pending <= 1'b0;
            gen_frame   <= '0;
        end else begin
            state <= state_next;

            // Issue spends one credit, each departing beat returns one
            case ({step, credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase

            if (frame_load) sof_pending <= 1'b1;
            else if (step)  sof_pending <= 1'b0;

            if (last_issue) gen_frame <= gen_frame + 1'b1;   // Wraps
        end
    end

endmodule

//--- logic/raster_counter.sv
/*
 * Raster counter
 * Walks x and y over the latched frame size and times the inter-frame gap
 */
`timescale 1ns/1ps

module raster_counter import video_pkg::*; (
    input  logic               aclk,
    input  logic               aresetn,
    input  logic               frame_load,
    input  logic               step,
    input  logic               gap_step,
    input  logic [X_WIDTH-1:0] param_width,
    input  logic [Y_WIDTH-1:0] param_height,
    output logic [X_WIDTH-1:0] x,
    output logic [Y_WIDTH-1:0] y,
    output logic               line_end,
    output logic               frame_end,
    output logic               gap_done
);

    logic [X_WIDTH-1:0]   width_q;    // Frame size for the frame in progress
    logic [Y_WIDTH-1:0]   height_q;
    logic [GAP_WIDTH-1:0] gap_cnt;

    // Position flags
    assign line_end  = (x == width_q - 1'b1);
    assign frame_end = line_end && (y == height_q - 1'b1);
    assign gap_done  = gap_step && (gap_cnt == GAP_WIDTH'(FRAME_GAP - 1));

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            width_q  <= '0;
            height_q <= '0;
            x        <= '0;
            y        <= '0;
        end else if (frame_load) begin
            width_q  <= param_width;
            height_q <= param_height;
            x        <= '0;
            y        <= '0;
        end else if (step) begin
            if (line_end) begin
                x <= '0;
                y <= frame_end ? '0 : y + 1'b1;
            end else begin
                x <= x + 1'b1;
            end
        end
    end

    // Gap timer
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            gap_cnt <= '0;
        end else if (!gap_step || gap_done) begin
            gap_cnt <= '0;
        end else begin
            gap_cnt <= gap_cnt + 1'b1;
        end
    end

endmodule

//--- logic/pattern_gen.sv
/*
 * Pattern generator
 * Combinational pixel from raster position and frame index,
 * gradient or packed coordinate mode
 */
`timescale 1ns/1ps

module pattern_gen import video_pkg::*; (
    input  logic               pattern_mode,
    input  logic [X_WIDTH-1:0] x,
    input  logic [Y_WIDTH-1:0] y,
    input  logic [F_WIDTH-1:0] gen_frame,
    output pixel_t             pixel
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Mode decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        pixel.word = '0;
        if (pattern_mode) begin
            // Coordinate word, row above column
            pixel.word = {y, x};
        end else begin
            // Gradient per component
            pixel.comp[0] = x[DATA_WIDTH-1:0];
            pixel.comp[1] = y[DATA_WIDTH-1:0];
            pixel.comp[2] = gen_frame[DATA_WIDTH-1:0];   // Shifts colour each frame
        end
    end

endmodule

//--- logic/stream_out_buffer.sv
/*
 * Output stream buffer
 * Two-entry FIFO to the pixel stream, with component swap,
 * credit return per departing beat and a completed-frame count
 */
`timescale 1ns/1ps

module stream_out_buffer import video_pkg::*; (
    input  logic               aclk,
    input  logic               aresetn,
    input  logic               wr_en,
    input  pixel_t             wr_pixel,
    input  logic               wr_sof,
    input  logic               wr_eol,
    input  logic               wr_eof,
    input  logic               component_swap,
    input  logic               m_tready,
    output pixel_t             m_tdata,
    output logic               m_tuser,
    output logic               m_tlast,
    output logic               m_tvalid,
    output logic               credit_return,
    output logic [F_WIDTH-1:0] frame_num
);

    pixel_t                  mem_pixel [BUF_DEPTH];
    logic                    mem_sof   [BUF_DEPTH];
    logic                    mem_eol   [BUF_DEPTH];
    logic                    mem_eof   [BUF_DEPTH];
    logic [PTR_WIDTH-1:0]    wr_ptr;
    logic [PTR_WIDTH-1:0]    rd_ptr;
    logic [CREDIT_WIDTH-1:0] count;      // Entries held, 0..BUF_DEPTH
    logic                    rd_en;
    pixel_t                  swap_pixel;

    // Reverse component order on entry so held beats stay stable
    always_comb begin
        swap_pixel = wr_pixel;
        if (component_swap) begin
            for (int i = 0; i < COMPONENTS; i++) begin
                swap_pixel.comp[i] = wr_pixel.comp[COMPONENTS-1-i];
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign m_tvalid      = (count != '0);
    assign m_tdata       = mem_pixel[rd_ptr];
    assign m_tuser       = mem_sof[rd_ptr];
    assign m_tlast       = mem_eol[rd_ptr];
    assign rd_en         = m_tvalid && m_tready;
    assign credit_return = rd_en;      // One credit back per transfer

    // Storage, written only with a credit in hand
    always_ff @(posedge aclk) begin
        if (wr_en) begin
            mem_pixel[wr_ptr] <= swap_pixel;
            mem_sof[wr_ptr]   <= wr_sof;
            mem_eol[wr_ptr]   <= wr_eol;
            mem_eof[wr_ptr]   <= wr_eof;
        end
    end

    // Pointers, fill level and frame count
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            frame_num <= '0;
        end else begin
            if (wr_en) wr_ptr <= (wr_ptr == PTR_WIDTH'(BUF_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (rd_en) rd_ptr <= (rd_ptr == PTR_WIDTH'(BUF_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;

            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase

            if (rd_en && mem_eof[rd_ptr]) frame_num <= frame_num + 1'b1;
        end
    end

endmodule

//--- logic/video_source_top.sv
/*
 * Video test-pattern source
 * Frame controller, raster counter, pattern generator and output buffer
 * behind one valid/ready pixel stream
 */
`timescale 1ns/1ps

module video_source_top import video_pkg::*; (
    input  logic               aclk,
    input  logic               aresetn,
    input  logic               enable,
    input  logic               pattern_mode,
    input  logic               component_swap,
    input  logic [X_WIDTH-1:0] param_width,
    input  logic [Y_WIDTH-1:0] param_height,
    output pixel_t             m_tdata,
    output logic               m_tuser,
    output logic               m_tlast,
    output logic               m_tvalid,
    output logic [F_WIDTH-1:0] frame_num,
    input  logic               m_tready
);

    // Controller to counter
    logic               step;
    logic               gap_step;
    logic               frame_load;
    logic [X_WIDTH-1:0] x;
    logic [Y_WIDTH-1:0] y;
    logic               line_end;
    logic               frame_end;
    logic               gap_done;

    // Generator and buffer side
    logic               issue_sof;
    logic [F_WIDTH-1:0] gen_frame;
    pixel_t             pixel;
    logic               credit_return;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Instances
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    frame_ctrl_fsm u_ctrl (
        .aclk          (aclk),
        .aresetn       (aresetn),
        .enable        (enable),
        .line_end      (line_end),
        .frame_end     (frame_end),
        .gap_done      (gap_done),
        .credit_return (credit_return),
        .step          (step),
        .gap_step      (gap_step),
        .frame_load    (frame_load),
        .issue_sof     (issue_sof),
        .gen_frame     (gen_frame)
    );

    raster_counter u_raster (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .frame_load   (frame_load),
        .step         (step),
        .gap_step     (gap_step),
        .param_width  (param_width),
        .param_height (param_height),
        .x            (x),
        .y            (y),
        .line_end     (line_end),
        .frame_end    (frame_end),
        .gap_done     (gap_done)
    );

    pattern_gen u_pattern (
        .pattern_mode (pattern_mode),
        .x            (x),
        .y            (y),
        .gen_frame    (gen_frame),
        .pixel        (pixel)
    );

    stream_out_buffer u_buffer (
        .aclk           (aclk),
        .aresetn        (aresetn),
        .wr_en          (step),        // Every issue is a write
        .wr_pixel       (pixel),
        .wr_sof         (issue_sof),
        .wr_eol         (line_end),
        .wr_eof         (frame_end),
        .component_swap (component_swap),
        .m_tready       (m_tready),
        .m_tdata        (m_tdata),
        .m_tuser        (m_tuser),
        .m_tlast        (m_tlast),
        .m_tvalid       (m_tvalid),
        .credit_return  (credit_return),
        .frame_num      (frame_num)
    );

endmodule

//--- verif/video_source_assertions.sv
/*
 * Output stream assertions
 * Handshake stability, frame-start position and reset behaviour
 */
`timescale 1ns/1ps

module video_source_assertions import video_pkg::*; (
    input logic   aclk,
    input logic   aresetn,
    input pixel_t m_tdata,
    input logic   m_tuser,
    input logic   m_tlast,
    input logic   m_tvalid,
    input logic   m_tready
);

    int   line_pos;             // Beats accepted since the last end of line
    logic reset_seen;
    int   assert_errors = 0;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            line_pos   <= 0;
            reset_seen <= 1'b1;    // Set once a reset edge has passed
        end else if (m_tvalid && m_tready) begin
            line_pos <= m_tlast ? 0 : line_pos + 1;
        end
    end

    // Stalled beat holds until it transfers
    assert property (@(posedge aclk) disable iff (!aresetn)
        m_tvalid && !m_tready |=> m_tvalid && $stable(m_tdata) && $stable(m_tuser)
            && $stable(m_tlast))
    else begin
        assert_errors++;
        $error("output beat changed or dropped while stalled");
    end

    assert property (@(posedge aclk) disable iff (!aresetn)
        m_tvalid && m_tuser |-> line_pos == 0)
    else begin
        assert_errors++;
        $error("frame start marker away from the first beat of a line");
    end

    assert property (@(posedge aclk) !aresetn && reset_seen |-> !m_tvalid)
    else begin
        assert_errors++;
        $error("stream valid during reset");
    end

endmodule

bind video_source_top video_source_assertions u_assertions (.*);

//--- verif/frame_capture_checker.sv
/*
 * Frame capture checker
 * Pixel stream sink with random ready that tracks the raster position
 * and compares every accepted beat
 */
`timescale 1ns/1ps

module frame_capture_checker import video_pkg::*; (
    input  logic               aclk,
    input  logic               aresetn,
    input  pixel_t             m_tdata,
    input  logic               m_tuser,
    input  logic               m_tlast,
    input  logic               m_tvalid,
    output logic               m_tready,
    input  int                 busy_rate,       // Percent of cycles with ready low
    input  logic               pattern_mode,
    input  logic               component_swap,
    input  logic [X_WIDTH-1:0] param_width,
    input  logic [Y_WIDTH-1:0] param_height
);

    int     seed = 32'hfd50_59ec;
    int     draw;
    int     exp_x = 0;
    int     exp_y = 0;
    int     frame_idx = 0;
    int     cur_w = 0;          // Size of the frame being captured
    int     cur_h = 0;
    int     beat_total = 0;
    int     test_beats = 0;
    int     test_errors = 0;
    int     total_errors = 0;
    int     tests_run = 0;
    pixel_t want_pixel;
    logic   want_user;
    logic   want_last;

    // Ready changes just after each edge
    initial begin
        m_tready = 1'b0;
        forever begin
            @(posedge aclk);
            #1;
            draw     = $random(seed);
            m_tready = ($unsigned(draw) % 100) >= busy_rate;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Beat compare
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(posedge aclk) begin
        if (aresetn && m_tvalid && m_tready) begin
            if (exp_x == 0 && exp_y == 0) begin
                cur_w = int'(param_width);
                cur_h = int'(param_height);
            end
            want_pixel = tb_video_source.expected_pixel(exp_x, exp_y, frame_idx,
                                                        pattern_mode, component_swap);
            want_user  = (exp_x == 0) && (exp_y == 0);
            want_last  = (exp_x == cur_w - 1);
            if (m_tdata !== want_pixel) begin
                $display("FAIL m_tdata: expected 0x%06h got 0x%06h (frame %0d x %0d y %0d)",
                         want_pixel.word, m_tdata.word, frame_idx, exp_x, exp_y);
                test_errors++;
                total_errors++;
            end
            if (m_tuser !== want_user) begin
                $display("FAIL m_tuser: expected 0x%0h got 0x%0h (x %0d y %0d)",
                         want_user, m_tuser, exp_x, exp_y);
                test_errors++;
                total_errors++;
            end
            if (m_tlast !== want_last) begin
                $display("FAIL m_tlast: expected 0x%0h got 0x%0h (x %0d y %0d)",
                         want_last, m_tlast, exp_x, exp_y);
                test_errors++;
                total_errors++;
            end
            beat_total++;
            test_beats++;

            // Advance own raster position
            if (exp_x == cur_w - 1) begin
                exp_x = 0;
                if (exp_y == cur_h - 1) begin
                    exp_y = 0;
                    frame_idx++;
                end else begin
                    exp_y++;
                end
            end else begin
                exp_x++;
            end
        end
    end

    task automatic end_test(input string name, input int seq_errors);
        $display("test %s: %0d beats, %0d errors", name, test_beats, test_errors + seq_errors);
        tests_run++;
        test_beats  = 0;
        test_errors = 0;
    endtask

endmodule

//--- verif/tb_video_source.sv
/*
 * Video source testbench
 * Clock, reset, frame sequencing and the reference pixel model
 */
`timescale 1ns/1ps

module tb_video_source import video_pkg::*; ();

    localparam int WAIT_LIMIT   = 4000;     // Cycles allowed per wait loop
    localparam int QUIET_CYCLES = 40;       // Well past FRAME_GAP
    localparam int WATCHDOG_NS  = 200_000;

    logic               aclk;
    logic               aresetn;
    logic               enable;
    logic               pattern_mode;
    logic               component_swap;
    logic [X_WIDTH-1:0] param_width;
    logic [Y_WIDTH-1:0] param_height;
    pixel_t             m_tdata;
    logic               m_tuser;
    logic               m_tlast;
    logic               m_tvalid;
    logic               m_tready;
    logic [F_WIDTH-1:0] frame_num;
    int                 busy_rate;
    int                 tb_errors;
    int                 test_errors;    // Sequencing errors of the running test
    int                 total_errors;

    initial aclk = 1'b0;
    always #2 aclk = ~aclk;

    video_source_top dut0 (.*);

    frame_capture_checker chk0 (.*);

    // Expected pixel from position, frame index and the two settings
    function automatic pixel_t expected_pixel(input int px, input int py, input int frame,
                                              input logic mode, input logic swap);
        pixel_t p;
        pixel_t r;
        if (mode) begin
            p.word = {py[Y_WIDTH-1:0], px[X_WIDTH-1:0]};
        end else begin
            p.comp[0] = px[DATA_WIDTH-1:0];
            p.comp[1] = py[DATA_WIDTH-1:0];
            p.comp[2] = frame[DATA_WIDTH-1:0];
        end
        r = p;
        if (swap) begin
            for (int i = 0; i < COMPONENTS; i++) r.comp[i] = p.comp[COMPONENTS-1-i];
        end
        return r;
    endfunction

    task automatic next_cycle();
        @(posedge aclk);
        #1;
    endtask

    task automatic wait_beats(input int target);
        int cycles = 0;
        while (chk0.beat_total < target && cycles < WAIT_LIMIT) begin
            next_cycle();
            cycles++;
        end
        if (chk0.beat_total < target) begin
            $display("timed out waiting for beat %0d", target);
            test_errors++;
        end
    endtask

    task automatic wait_frames(input int target);
        int cycles = 0;
        while (int'(frame_num) < target && cycles < WAIT_LIMIT) begin
            next_cycle();
            cycles++;
        end
        if (int'(frame_num) < target) begin
            $display("timed out waiting for frame count %0d", target);
            test_errors++;
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Test steps
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic finish_test(input string name, input int frames_want, input int beats_want);
        wait_frames(frames_want);
        repeat (QUIET_CYCLES) next_cycle();     // No extra frame may start
        if (int'(frame_num) != frames_want) begin
            $display("FAIL frame_num: expected 0x%04h got 0x%04h", frames_want, frame_num);
            test_errors++;
        end
        if (chk0.beat_total != beats_want) begin
            $display("wrong number of beats: expected %0d got %0d", beats_want,
                     chk0.beat_total);
            test_errors++;
        end
        if (m_tvalid) begin
            $display("stream still valid after the last frame ended");
            test_errors++;
        end
        chk0.end_test(name, test_errors);
        tb_errors += test_errors;
        test_errors = 0;
    endtask

    // Enable drops once beat number drop_at of the last frame is accepted
    task automatic run_frames(input string name, input int w, input int h, input logic mode,
                              input logic swap, input int busy, input int n, input int drop_at);
        int frames_before = int'(frame_num);
        int beats_before  = chk0.beat_total;
        param_width    = X_WIDTH'(w);
        param_height   = Y_WIDTH'(h);
        pattern_mode   = mode;
        component_swap = swap;
        busy_rate      = busy;
        enable         = 1'b1;
        wait_beats(beats_before + (n - 1) * w * h + drop_at);
        enable = 1'b0;
        finish_test(name, frames_before + n, beats_before + n * w * h);
    endtask

    task automatic size_change_test();
        int frames_before = int'(frame_num);
        int beats_before  = chk0.beat_total;
        param_width    = X_WIDTH'(6);
        param_height   = Y_WIDTH'(2);
        pattern_mode   = 1'b1;
        component_swap = 1'b0;
        busy_rate      = 25;
        enable         = 1'b1;
        wait_beats(beats_before + 1);
        param_width  = X_WIDTH'(3);             // Applies from the next frame start
        param_height = Y_WIDTH'(4);
        wait_beats(beats_before + 12 + 1);
        enable = 1'b0;
        finish_test("size change", frames_before + 2, beats_before + 24);
    endtask

    initial begin
        aresetn        = 1'b0;
        enable         = 1'b0;
        pattern_mode   = 1'b0;
        component_swap = 1'b0;
        param_width    = '0;
        param_height   = '0;
        busy_rate      = 0;
        tb_errors      = 0;
        test_errors    = 0;
        repeat (4) @(posedge aclk);
        #1 aresetn = 1'b1;
        next_cycle();

        run_frames("gradient 8x4", 8, 4, 1'b0, 1'b0, 0, 1, 1);
        run_frames("coordinate word 5x3", 5, 3, 1'b1, 1'b0, 0, 1, 1);
        run_frames("component swap", 6, 3, 1'b0, 1'b1, 20, 2, 1);
        run_frames("back-pressure", 7, 5, 1'b0, 1'b0, 70, 3, 1);
        run_frames("enable drop mid-frame", 10, 6, 1'b1, 1'b0, 40, 1, 30);
        size_change_test();

        total_errors = tb_errors + chk0.total_errors + dut0.u_assertions.assert_errors;
        $display("summary: %0d tests, %0d beats, %0d errors", chk0.tests_run,
                 chk0.beat_total, total_errors);
        if (total_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("simulation did not finish within the time limit");
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

//--- filelist.f
// Package first, then RTL bottom up
logic/video_pkg.sv
logic/frame_ctrl_fsm.sv
logic/raster_counter.sv
logic/pattern_gen.sv
logic/stream_out_buffer.sv
logic/video_source_top.sv
// Testbench
verif/video_source_assertions.sv
verif/frame_capture_checker.sv
verif/tb_video_source.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Verilator build and run for the video source testbench

cd "$(dirname "$0")" || exit 1
top=tb_video_source
log=sim.log

verilator --binary --timing --assert --top-module "$top" -f filelist.f -o "V$top"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

# Let assertion errors accumulate so the testbench reaches its summary
"./obj_dir/V$top" +verilator+error+limit+100 > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "ALL CHECKS PASSED" "$log"; then
    exit 0
fi
echo "pass message not found in $log"
exit 1
